// File: rtl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define DATA_W 32
`define REG_W 5
`define MD_ITER 32

`endif

// File: rtl/instrPkg.sv
`default_nettype none
`include "mips_consts.svh"

package instrPkg;

    typedef enum logic [5:0] {
        opNop,
        opAdd, opAddu, opSub, opSubu,
        opAnd, opOr, opXor, opNor,
        opSlt, opSltu,
        opSll, opSrl, opSra,
        opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opSltiu, opLui,
        opLb, opLbu, opLh, opLhu, opLw,
        opSb, opSh, opSw,
        opMul, opMult, opMultu, opDiv, opDivu,
        opMfhi, opMflo
    } opCode;

    typedef struct packed {
        opCode op;
        logic [`REG_W-1:0] rsNum;
        logic [`REG_W-1:0] rtNum;
        logic [`REG_W-1:0] destNum; // zero means the instruction writes no register.
        logic [4:0] shamt;
        logic [15:0] imm16;
    } decodedInstr;

endpackage

`default_nettype wire

// File: rtl/stagePkg.sv
`default_nettype none
`include "mips_consts.svh"

package stagePkg;

    typedef enum logic [2:0] {
        extNone,
        extByteSigned,
        extByteUnsigned,
        extHalfSigned,
        extHalfUnsigned,
        extWord
    } extKind;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        logic [`REG_W-1:0] destNum;
        logic writeEn;
        logic [`DATA_W-1:0] data;
        logic overflow;
        logic unaligned;
    } execResult;

    typedef struct packed {
        logic read;
        logic write;
        logic [3:0] byteEn;
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] writeData;
        extKind ext;
    } memRequest;

endpackage

`default_nettype wire

// File: rtl/mulDivIf.sv
`default_nettype none
`include "mips_consts.svh"

interface mulDivIf;
    logic start; // a one-cycle pulse that is legal only while busy is low.
    instrPkg::opCode op;
    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] srcB;
    logic busy;
    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;
    logic flush;

    modport ctrl (
        output start, op, srcA, srcB, flush,
        input  busy, hi, lo
    );

    modport unit (
        input  start, op, srcA, srcB, flush,
        output busy, hi, lo
    );
endinterface

`default_nettype wire

// File: rtl/operandForward.sv
`default_nettype none
`include "mips_consts.svh"

module operandForward (
    input  wire logic [`REG_W-1:0]  srcNum,
    input  wire logic [`DATA_W-1:0] regData,
    input  wire logic               exValid,
    input  wire logic               exWriteEn,
    input  wire logic [`REG_W-1:0]  exDest,
    input  wire logic [`DATA_W-1:0] exData,
    input  wire logic               memWriteEn,
    input  wire logic [`REG_W-1:0]  memNum,
    input  wire logic [`DATA_W-1:0] memData,
    output logic [`DATA_W-1:0]      operand
);
    logic exHit;
    logic memHit;

    assign exHit = exValid && exWriteEn && exDest == srcNum;
    assign memHit = memWriteEn && memNum == srcNum;

    // the execute result is younger than the memory stage, so it wins.
    assign operand = (srcNum == '0) ? regData :
                     exHit          ? exData  :
                     memHit         ? memData : regData;

endmodule

`default_nettype wire

// File: rtl/intAlu.sv
`default_nettype none
`include "mips_consts.svh"

module intAlu (
    input  wire instrPkg::opCode    op,
    input  wire logic [`DATA_W-1:0] srcA,
    input  wire logic [`DATA_W-1:0] srcB,
    input  wire logic [4:0]         shamt,
    input  wire logic [15:0]        imm16,
    input  wire logic [`DATA_W-1:0] hi,
    input  wire logic [`DATA_W-1:0] lo,
    output logic [`DATA_W-1:0]      result,
    output logic                    overflow
);
    localparam int Msb = `DATA_W - 1;

    logic isMem;
    logic zeroExt;
    logic useImm;
    logic [`DATA_W-1:0] immExt;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic ltSigned;
    logic ltUnsigned;

    assign isMem = op inside {instrPkg::opLb, instrPkg::opLbu, instrPkg::opLh,
                              instrPkg::opLhu, instrPkg::opLw, instrPkg::opSb,
                              instrPkg::opSh, instrPkg::opSw};
    assign zeroExt = op inside {instrPkg::opAndi, instrPkg::opOri, instrPkg::opXori};
    assign useImm = isMem || zeroExt ||
                    op inside {instrPkg::opAddi, instrPkg::opAddiu,
                               instrPkg::opSlti, instrPkg::opSltiu};

    assign immExt = zeroExt ? {{(`DATA_W-16){1'b0}}, imm16} : {{(`DATA_W-16){imm16[15]}}, imm16};
    assign opB = useImm ? immExt : srcB;
    assign sum = srcA + opB;
    assign diff = srcA - srcB;
    assign ltSigned = $signed(srcA) < $signed(opB);
    assign ltUnsigned = srcA < opB; // sltiu compares the sign-extended immediate unsigned.

    always_comb begin
        case (op)
            instrPkg::opSub, instrPkg::opSubu: result = diff;
            instrPkg::opAnd, instrPkg::opAndi: result = srcA & opB;
            instrPkg::opOr, instrPkg::opOri:   result = srcA | opB;
            instrPkg::opXor, instrPkg::opXori: result = srcA ^ opB;
            instrPkg::opNor:   result = ~(srcA | srcB);
            instrPkg::opSlt, instrPkg::opSlti:   result = {{Msb{1'b0}}, ltSigned};
            instrPkg::opSltu, instrPkg::opSltiu: result = {{Msb{1'b0}}, ltUnsigned};
            instrPkg::opSll:   result = srcB << shamt;
            instrPkg::opSrl:   result = srcB >> shamt;
            instrPkg::opSra:   result = $signed(srcB) >>> shamt;
            instrPkg::opLui:   result = {imm16, {(`DATA_W-16){1'b0}}};
            instrPkg::opMfhi:  result = hi;
            instrPkg::opMflo:  result = lo;
            instrPkg::opAdd, instrPkg::opAddu,
            instrPkg::opAddi, instrPkg::opAddiu: result = sum;
            default: result = isMem ? sum : '0; // loads and stores yield the address.
        endcase
    end

    always_comb begin
        if (op inside {instrPkg::opAdd, instrPkg::opAddi}) begin
            overflow = srcA[Msb] == opB[Msb] && sum[Msb] != srcA[Msb];
        end else if (op == instrPkg::opSub) begin
            overflow = srcA[Msb] != srcB[Msb] && diff[Msb] != srcA[Msb];
        end else begin
            overflow = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mulDivUnit.sv
`default_nettype none
`include "mips_consts.svh"

module mulDivUnit (
    input wire logic Clk,
    input wire logic arstN,
    mulDivIf.unit    md
);
    localparam int W = `DATA_W;
    localparam int CntW = $clog2(`MD_ITER);

    logic startSigned;
    logic startDiv;
    logic [W-1:0] magA;
    logic [W-1:0] magB;
    logic [CntW-1:0] count;
    logic [2*W-1:0] acc; // remainder:quotient for divide, running product for multiply.
    logic [2*W-1:0] accNext;
    logic [W:0] trial;
    logic [W-1:0] opMag;
    logic divMode;
    logic negQuo;
    logic negRem;
    logic [2*W-1:0] product;
    logic [W-1:0] quotient;
    logic [W-1:0] remainder;

    assign startSigned = md.op inside {instrPkg::opMul, instrPkg::opMult, instrPkg::opDiv};
    assign startDiv = md.op inside {instrPkg::opDiv, instrPkg::opDivu};
    assign magA = (startSigned && md.srcA[W-1]) ? -md.srcA : md.srcA;
    assign magB = (startSigned && md.srcB[W-1]) ? -md.srcB : md.srcB;

    always_comb begin
        if (divMode) begin
            trial = acc[2*W-1:W-1] - {1'b0, opMag};
            accNext = trial[W] ? {acc[2*W-2:0], 1'b0} : {trial[W-1:0], acc[W-2:0], 1'b1};
        end else begin
            trial = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, opMag} : {(W+1){1'b0}});
            accNext = {trial, acc[W-1:1]};
        end
    end

    assign product = negQuo ? -accNext : accNext;
    assign quotient = negQuo ? -accNext[W-1:0] : accNext[W-1:0];
    assign remainder = negRem ? -accNext[2*W-1:W] : accNext[2*W-1:W];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            md.busy <= 1'b0;
            count <= '0;
            md.hi <= '0;
            md.lo <= '0;
        end else if (md.flush) begin
            md.busy <= 1'b0;
        end else if (md.start) begin
            md.busy <= 1'b1;
            count <= '0;
        end else if (md.busy) begin
            count <= count + 1'b1;
            if (count == CntW'(`MD_ITER - 1)) begin // last step writes the final values.
                md.busy <= 1'b0;
                md.hi <= divMode ? remainder : product[2*W-1:W];
                md.lo <= divMode ? quotient : product[W-1:0];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (md.start) begin
            acc <= {{W{1'b0}}, magA};
            opMag <= magB;
            divMode <= startDiv;
            // a zero divisor keeps the all-ones quotient unsigned.
            negQuo <= startSigned && (md.srcA[W-1] ^ md.srcB[W-1]) &&
                      !(startDiv && md.srcB == '0);
            negRem <= startSigned && md.srcA[W-1];
        end else if (md.busy) begin
            acc <= accNext;
        end
    end

endmodule

`default_nettype wire

// File: rtl/memAccessGen.sv
`default_nettype none
`include "mips_consts.svh"

module memAccessGen (
    input  wire instrPkg::opCode    op,
    input  wire logic [`DATA_W-1:0] addr,
    input  wire logic [`DATA_W-1:0] storeData,
    output logic                    read,
    output logic                    write,
    output logic [3:0]              byteEn,
    output logic [`DATA_W-1:0]      writeData,
    output stagePkg::extKind        ext,
    output logic                    unaligned
);
    logic isLoad;
    logic isStore;
    logic isByte;
    logic isHalf;
    logic [3:0] lanes;
    logic misaligned;

    assign isStore = op inside {instrPkg::opSb, instrPkg::opSh, instrPkg::opSw};
    assign isLoad = ext != stagePkg::extNone;
    assign isByte = op inside {instrPkg::opLb, instrPkg::opLbu, instrPkg::opSb};
    assign isHalf = op inside {instrPkg::opLh, instrPkg::opLhu, instrPkg::opSh};

    assign lanes = isByte ? 4'b0001 << addr[1:0] :
                   isHalf ? 4'b0011 << addr[1:0] : 4'b1111;
    assign misaligned = isHalf ? addr[0] : !isByte && addr[1:0] != 2'b00;

    assign unaligned = (isLoad || isStore) && misaligned;
    assign read = isLoad && !unaligned;
    assign write = isStore && !unaligned;
    assign byteEn = (read || write) ? lanes : 4'b0000;
    assign writeData = isByte ? {4{storeData[7:0]}} :
                       isHalf ? {2{storeData[15:0]}} : storeData; // copy into every lane.

    always_comb begin
        case (op)
            instrPkg::opLb:  ext = stagePkg::extByteSigned;
            instrPkg::opLbu: ext = stagePkg::extByteUnsigned;
            instrPkg::opLh:  ext = stagePkg::extHalfSigned;
            instrPkg::opLhu: ext = stagePkg::extHalfUnsigned;
            instrPkg::opLw:  ext = stagePkg::extWord;
            default:         ext = stagePkg::extNone;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/execStage.sv
`default_nettype none
`include "mips_consts.svh"

module execStage (
    input  wire logic               Clk,
    input  wire logic               arstN,
    input  wire logic               flush,
    input  wire logic               memStall,
    input  wire logic               inValid,
    input  wire instrPkg::opCode    inOp,
    input  wire logic [`DATA_W-1:0] inPc,
    input  wire logic [`REG_W-1:0]  rsNum,
    input  wire logic [`REG_W-1:0]  rtNum,
    input  wire logic [`REG_W-1:0]  destNum,
    input  wire logic [4:0]         shamt,
    input  wire logic [15:0]        imm16,
    input  wire logic [`DATA_W-1:0] rsData,
    input  wire logic [`DATA_W-1:0] rtData,
    input  wire logic               memFwdWriteEn,
    input  wire logic [`REG_W-1:0]  memFwdNum,
    input  wire logic [`DATA_W-1:0] memFwdData,
    output logic                    busy,
    output logic                    outValid,
    output logic [`DATA_W-1:0]      outPc,
    output logic [`REG_W-1:0]       outDest,
    output logic                    outWriteEn,
    output logic [`DATA_W-1:0]      outData,
    output logic                    outOverflow,
    output logic                    outUnaligned,
    output logic                    memRead,
    output logic                    memWrite,
    output logic [3:0]              memByteEn,
    output logic [`DATA_W-1:0]      memAddr,
    output logic [`DATA_W-1:0]      memWriteData,
    output stagePkg::extKind        memExt
);
    instrPkg::decodedInstr inInstr;
    instrPkg::decodedInstr parkInstr;
    logic [`DATA_W-1:0] parkPc;
    logic parkValid;
    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluResult;
    logic aluOverflow;
    logic accRead;
    logic accWrite;
    logic [3:0] accByteEn;
    logic [`DATA_W-1:0] accWriteData;
    stagePkg::extKind accExt;
    logic accUnaligned;
    logic isMulDiv;
    logic isHiLoRead;
    logic writesReg;
    logic accept;
    logic issue;
    logic retire;
    stagePkg::execResult exRes;
    stagePkg::execResult aluRes;
    stagePkg::execResult parkRes;
    stagePkg::memRequest memReq;
    stagePkg::memRequest aluReq;

    mulDivIf md ();

    assign inInstr = '{op: inOp, rsNum: rsNum, rtNum: rtNum, destNum: destNum,
                       shamt: shamt, imm16: imm16};

    operandForward fwdRs (
        .srcNum(inInstr.rsNum), .regData(rsData),
        .exValid(outValid), .exWriteEn(exRes.writeEn), .exDest(exRes.destNum),
        .exData(exRes.data), .memWriteEn(memFwdWriteEn), .memNum(memFwdNum),
        .memData(memFwdData), .operand(srcA)
    );

    operandForward fwdRt (
        .srcNum(inInstr.rtNum), .regData(rtData),
        .exValid(outValid), .exWriteEn(exRes.writeEn), .exDest(exRes.destNum),
        .exData(exRes.data), .memWriteEn(memFwdWriteEn), .memNum(memFwdNum),
        .memData(memFwdData), .operand(srcB)
    );

    intAlu alu (
        .op(inInstr.op), .srcA(srcA), .srcB(srcB), .shamt(inInstr.shamt),
        .imm16(inInstr.imm16), .hi(md.hi), .lo(md.lo),
        .result(aluResult), .overflow(aluOverflow)
    );

    memAccessGen memGen (
        .op(inInstr.op), .addr(aluResult), .storeData(srcB),
        .read(accRead), .write(accWrite), .byteEn(accByteEn),
        .writeData(accWriteData), .ext(accExt), .unaligned(accUnaligned)
    );

    mulDivUnit mdUnit (.Clk(Clk), .arstN(arstN), .md(md.unit));

    assign isMulDiv = inInstr.op inside {instrPkg::opMul, instrPkg::opMult, instrPkg::opMultu,
                                         instrPkg::opDiv, instrPkg::opDivu};
    assign isHiLoRead = inInstr.op inside {instrPkg::opMfhi, instrPkg::opMflo};
    assign writesReg = inInstr.destNum != '0 &&
                       !(inInstr.op inside {instrPkg::opSb, instrPkg::opSh,
                                            instrPkg::opSw, instrPkg::opNop});

    // a parked op blocks everything and hi/lo readers wait for the unit.
    assign busy = parkValid || (inValid && (isMulDiv || isHiLoRead) && md.busy);
    assign accept = inValid && !busy && !memStall;
    assign issue = accept && !isMulDiv;
    assign retire = parkValid && !md.busy;

    assign md.start = accept && isMulDiv && !flush;
    assign md.op = inInstr.op;
    assign md.srcA = srcA;
    assign md.srcB = srcB;
    assign md.flush = flush;

    assign aluRes = '{pc: inPc, destNum: inInstr.destNum, writeEn: issue && writesReg,
                      data: aluResult, overflow: issue && aluOverflow,
                      unaligned: issue && accUnaligned};
    assign aluReq = '{read: issue && accRead, write: issue && accWrite,
                      byteEn: issue ? accByteEn : 4'b0000, addr: aluResult,
                      writeData: accWriteData, ext: accExt};
    assign parkRes = '{pc: parkPc, destNum: parkInstr.destNum,
                       writeEn: parkInstr.op == instrPkg::opMul && parkInstr.destNum != '0,
                       data: md.lo, overflow: 1'b0, unaligned: 1'b0}; // only mul writes lo.

    always_ff @(posedge Clk) begin
        if (md.start) begin
            parkInstr <= inInstr;
            parkPc <= inPc;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            parkValid <= 1'b0;
            exRes <= '0;
            memReq <= '0;
        end else if (flush) begin
            outValid <= 1'b0;
            parkValid <= 1'b0;
            exRes <= '0;
            memReq <= '0;
        end else if (!memStall) begin
            if (retire) begin
                outValid <= 1'b1;
                parkValid <= 1'b0;
                exRes <= parkRes;
                memReq <= '0;
            end else begin
                outValid <= issue;
                parkValid <= parkValid || md.start;
                exRes <= aluRes;
                memReq <= aluReq;
            end
        end
    end

    assign outPc = exRes.pc;
    assign outDest = exRes.destNum;
    assign outWriteEn = exRes.writeEn;
    assign outData = exRes.data;
    assign outOverflow = exRes.overflow;
    assign outUnaligned = exRes.unaligned;
    assign memRead = memReq.read;
    assign memWrite = memReq.write;
    assign memByteEn = memReq.byteEn;
    assign memAddr = memReq.addr;
    assign memWriteData = memReq.writeData;
    assign memExt = memReq.ext;

endmodule

`default_nettype wire

// File: testbench/execStageTb.sv
`default_nettype none
`include "mips_consts.svh"

module execStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = `DATA_W;
    localparam int NumInstr = 300;
    localparam int ClkPeriod = 40;
    localparam int NumOps = int'(instrPkg::opMflo) + 1;

    logic Clk = 1'b0;
    logic arstN;
    logic flush;
    logic memStall;
    logic inValid;
    instrPkg::opCode inOp;
    logic [W-1:0] inPc;
    logic [`REG_W-1:0] rsNum;
    logic [`REG_W-1:0] rtNum;
    logic [`REG_W-1:0] destNum;
    logic [4:0] shamt;
    logic [15:0] imm16;
    logic [W-1:0] rsData;
    logic [W-1:0] rtData;
    logic memFwdWriteEn;
    logic [`REG_W-1:0] memFwdNum;
    logic [W-1:0] memFwdData;
    logic busy;
    logic outValid;
    logic [W-1:0] outPc;
    logic [`REG_W-1:0] outDest;
    logic outWriteEn;
    logic [W-1:0] outData;
    logic outOverflow;
    logic outUnaligned;
    logic memRead;
    logic memWrite;
    logic [3:0] memByteEn;
    logic [W-1:0] memAddr;
    logic [W-1:0] memWriteData;
    stagePkg::extKind memExt;

    integer seed = 47;

    // the model state mirrors what the DUT registers hold after the next edge.
    logic expValid;
    logic [W-1:0] expPc;
    logic [`REG_W-1:0] expDest;
    logic expWriteEn;
    logic [W-1:0] expData;
    logic expOverflow;
    logic expUnaligned;
    logic expRead;
    logic expWrite;
    logic [3:0] expByteEn;
    logic [W-1:0] expAddr;
    logic [W-1:0] expWriteData;
    stagePkg::extKind expExt;
    logic [W-1:0] mdHi;
    logic [W-1:0] mdLo;
    logic [W-1:0] pendHi;
    logic [W-1:0] pendLo;
    int unitCount; // cycles left until the multiply/divide unit drops busy.
    logic parked;
    logic [W-1:0] parkPc;
    logic [`REG_W-1:0] parkDest;
    logic parkIsMul;
    logic holdInstr;
    logic draining;
    int numAccepted;

    execStage u_execStage (.*);

    always #(ClkPeriod / 2) Clk = ~Clk;

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [W-1:0] randomData();
        case (pick(16))
            0: return '0;
            1: return 32'h8000_0000;
            2: return 32'h7fff_ffff;
            3: return '1;
            default: return $random(seed);
        endcase
    endfunction

    function automatic logic isLoadOp(input instrPkg::opCode op);
        return op inside {instrPkg::opLb, instrPkg::opLbu, instrPkg::opLh,
                          instrPkg::opLhu, instrPkg::opLw};
    endfunction

    function automatic logic isStoreOp(input instrPkg::opCode op);
        return op inside {instrPkg::opSb, instrPkg::opSh, instrPkg::opSw};
    endfunction

    function automatic logic isMulDivOp(input instrPkg::opCode op);
        return op inside {instrPkg::opMul, instrPkg::opMult, instrPkg::opMultu,
                          instrPkg::opDiv, instrPkg::opDivu};
    endfunction

    task automatic expectEqual(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // the youngest producer wins and register zero always reads the register file.
    function automatic logic [W-1:0] forwardOperand(input logic [`REG_W-1:0] num,
                                                    input logic [W-1:0] regData);
        if (num == '0) return regData;
        if (expValid && expWriteEn && expDest == num) return expData;
        if (memFwdWriteEn && memFwdNum == num) return memFwdData;
        return regData;
    endfunction

    task automatic aluModel(input instrPkg::opCode op, input logic [W-1:0] a,
                            input logic [W-1:0] b, output logic [W-1:0] res, output logic ovf);
        logic [W-1:0] se;
        logic [W-1:0] ze;
        se = {{(W-16){imm16[15]}}, imm16};
        ze = {{(W-16){1'b0}}, imm16};
        ovf = 1'b0;
        case (op)
            instrPkg::opAdd: begin
                res = a + b;
                ovf = a[W-1] == b[W-1] && res[W-1] != a[W-1];
            end
            instrPkg::opAddu: res = a + b;
            instrPkg::opSub: begin
                res = a - b;
                ovf = a[W-1] != b[W-1] && res[W-1] != a[W-1];
            end
            instrPkg::opSubu: res = a - b;
            instrPkg::opAnd: res = a & b;
            instrPkg::opOr: res = a | b;
            instrPkg::opXor: res = a ^ b;
            instrPkg::opNor: res = ~(a | b);
            instrPkg::opSlt: res = W'($signed(a) < $signed(b));
            instrPkg::opSltu: res = W'(a < b);
            instrPkg::opSll: res = b << shamt;
            instrPkg::opSrl: res = b >> shamt;
            instrPkg::opSra: res = $signed(b) >>> shamt;
            instrPkg::opAddi: begin
                res = a + se;
                ovf = a[W-1] == se[W-1] && res[W-1] != a[W-1];
            end
            instrPkg::opAddiu: res = a + se;
            instrPkg::opAndi: res = a & ze;
            instrPkg::opOri: res = a | ze;
            instrPkg::opXori: res = a ^ ze;
            instrPkg::opSlti: res = W'($signed(a) < $signed(se));
            instrPkg::opSltiu: res = W'(a < se);
            instrPkg::opLui: res = {imm16, {(W-16){1'b0}}};
            instrPkg::opMfhi: res = mdHi;
            instrPkg::opMflo: res = mdLo;
            default: res = (isLoadOp(op) || isStoreOp(op)) ? a + se : '0;
        endcase
    endtask

    task automatic mulDivModel(input instrPkg::opCode op, input logic [W-1:0] a,
                               input logic [W-1:0] b, output logic [W-1:0] hiV,
                               output logic [W-1:0] loV);
        longint sa;
        longint sb;
        logic [2*W-1:0] pair;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        pair = '0;
        if (op == instrPkg::opMultu) begin
            pair = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        end else if (op == instrPkg::opMul || op == instrPkg::opMult) begin
            pair = sa * sb;
        end else if (b == '0) begin
            pair = {a, {W{1'b1}}}; // divide by zero keeps the dividend as remainder.
        end else if (op == instrPkg::opDiv) begin
            pair = {W'(sa % sb), W'(sa / sb)};
        end else begin
            pair = {a % b, a / b};
        end
        hiV = pair[2*W-1:W];
        loV = pair[W-1:0];
    endtask

    task automatic clearControls();
        expValid = 1'b0;
        expWriteEn = 1'b0;
        expOverflow = 1'b0;
        expUnaligned = 1'b0;
        expRead = 1'b0;
        expWrite = 1'b0;
        expByteEn = 4'b0000;
    endtask

    task automatic issueModel(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W-1:0] res;
        logic ovf;
        int size;
        logic bad;
        logic [3:0] lanes;
        aluModel(inOp, a, b, res, ovf);
        size = (inOp inside {instrPkg::opLb, instrPkg::opLbu, instrPkg::opSb}) ? 1 :
               (inOp inside {instrPkg::opLh, instrPkg::opLhu, instrPkg::opSh}) ? 2 : 4;
        bad = (size == 4 && res[1:0] != 2'b00) || (size == 2 && res[0]);
        lanes = (size == 1) ? 4'b0001 << res[1:0] :
                (size == 2) ? 4'b0011 << res[1:0] : 4'b1111;
        expValid = 1'b1;
        expPc = inPc;
        expDest = destNum;
        expWriteEn = destNum != '0 && !isStoreOp(inOp) && inOp != instrPkg::opNop;
        expData = res;
        expOverflow = ovf;
        expUnaligned = (isLoadOp(inOp) || isStoreOp(inOp)) && bad;
        expRead = isLoadOp(inOp) && !bad;
        expWrite = isStoreOp(inOp) && !bad;
        expByteEn = (expRead || expWrite) ? lanes : 4'b0000;
        expAddr = res;
        expWriteData = (size == 1) ? {4{b[7:0]}} : (size == 2) ? {2{b[15:0]}} : b;
        case (inOp)
            instrPkg::opLb: expExt = stagePkg::extByteSigned;
            instrPkg::opLbu: expExt = stagePkg::extByteUnsigned;
            instrPkg::opLh: expExt = stagePkg::extHalfSigned;
            instrPkg::opLhu: expExt = stagePkg::extHalfUnsigned;
            instrPkg::opLw: expExt = stagePkg::extWord;
            default: expExt = stagePkg::extNone;
        endcase
    endtask

    task automatic checkOutputs();
        expectEqual("outValid", W'(outValid), W'(expValid));
        expectEqual("outWriteEn", W'(outWriteEn), W'(expWriteEn));
        expectEqual("outOverflow", W'(outOverflow), W'(expOverflow));
        expectEqual("outUnaligned", W'(outUnaligned), W'(expUnaligned));
        expectEqual("memRead", W'(memRead), W'(expRead));
        expectEqual("memWrite", W'(memWrite), W'(expWrite));
        expectEqual("memByteEn", W'(memByteEn), W'(expByteEn));
        if (expValid) begin
            expectEqual("outPc", outPc, expPc);
            expectEqual("outDest", W'(outDest), W'(expDest));
            expectEqual("outData", outData, expData);
            expectEqual("memAddr", memAddr, expAddr);
            expectEqual("memWriteData", memWriteData, expWriteData);
            expectEqual("memExt", W'(memExt), W'(expExt));
        end
    endtask

    // advances the model by one clock edge using the inputs now presented.
    task automatic stepModel();
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic unitBusy;
        logic expBusy;
        logic accepted;
        logic startNow;
        unitBusy = unitCount > 0;
        expBusy = parked || (inValid && unitBusy &&
                  (isMulDivOp(inOp) || inOp inside {instrPkg::opMfhi, instrPkg::opMflo}));
        expectEqual("busy", W'(busy), W'(expBusy));
        accepted = inValid && !expBusy && !memStall;
        startNow = accepted && isMulDivOp(inOp) && !flush;
        holdInstr = inValid && !accepted && !flush;
        a = forwardOperand(rsNum, rsData);
        b = forwardOperand(rtNum, rtData);
        if (accepted) numAccepted++;
        if (flush) begin
            clearControls();
            parked = 1'b0;
        end else if (!memStall) begin
            if (parked && !unitBusy) begin
                clearControls();
                expValid = 1'b1;
                expPc = parkPc;
                expDest = parkDest;
                expWriteEn = parkIsMul && parkDest != '0; // only mul writes lo back.
                expData = mdLo;
                expAddr = '0;
                expWriteData = '0;
                expExt = stagePkg::extNone;
                parked = 1'b0;
            end else if (startNow) begin
                clearControls();
                parked = 1'b1;
                parkPc = inPc;
                parkDest = destNum;
                parkIsMul = inOp == instrPkg::opMul;
            end else if (accepted) begin
                issueModel(a, b);
            end else begin
                clearControls();
            end
        end
        if (flush) begin
            unitCount = 0; // hi and lo keep their old values.
        end else if (startNow) begin
            unitCount = `MD_ITER;
            mulDivModel(inOp, a, b, pendHi, pendLo);
        end else if (unitCount > 0) begin
            unitCount--;
            if (unitCount == 0) begin
                mdHi = pendHi;
                mdLo = pendLo;
            end
        end
    endtask

    task automatic driveInputs();
        memStall <= (pick(8) == 0);
        flush <= (pick(40) == 0);
        rsData <= randomData();
        rtData <= randomData();
        memFwdWriteEn <= (pick(2) == 0);
        memFwdNum <= `REG_W'(pick(8));
        memFwdData <= randomData();
        if (draining) begin
            inValid <= 1'b0;
        end else if (!holdInstr) begin
            inValid <= (pick(8) != 0);
            inOp <= instrPkg::opCode'(pick(NumOps));
            inPc <= inPc + W'(4);
            rsNum <= `REG_W'(pick(8)); // few registers keep hazards frequent.
            rtNum <= `REG_W'(pick(8));
            destNum <= `REG_W'(pick(8));
            shamt <= 5'(pick(32));
            imm16 <= 16'(pick(65536));
        end
    endtask

    task automatic runCycle();
        @(negedge Clk);
        checkOutputs();
        stepModel();
        @(posedge Clk);
        driveInputs();
    endtask

    initial begin
        arstN <= 1'b0;
        flush <= 1'b0;
        memStall <= 1'b0;
        inValid <= 1'b0;
        inOp <= instrPkg::opNop;
        inPc <= 32'h0040_0000;
        rsNum <= '0;
        rtNum <= '0;
        destNum <= '0;
        shamt <= '0;
        imm16 <= '0;
        rsData <= '0;
        rtData <= '0;
        memFwdWriteEn <= 1'b0;
        memFwdNum <= '0;
        memFwdData <= '0;
        clearControls();
        expExt = stagePkg::extNone;
        mdHi = '0;
        mdLo = '0;
        unitCount = 0;
        parked = 1'b0;
        holdInstr = 1'b0;
        draining = 1'b0;
        numAccepted = 0;
        repeat (4) begin
            @(negedge Clk);
            checkOutputs();
            expectEqual("busy", W'(busy), W'(1'b0));
        end
        @(posedge Clk);
        arstN <= 1'b1;
        driveInputs();
        while (numAccepted < NumInstr) runCycle();
        draining = 1'b1;
        while (parked || expValid || inValid) runCycle();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(NumInstr * (`MD_ITER + 10) * ClkPeriod);
        $display("Timeout: the run did not finish in time, the DUT seems to hang.");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
rtl/instrPkg.sv
rtl/stagePkg.sv
rtl/mulDivIf.sv
rtl/operandForward.sv
rtl/intAlu.sv
rtl/mulDivUnit.sv
rtl/memAccessGen.sv
rtl/execStage.sv
testbench/execStageTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module execStageTb
	./obj_dir/VexecStageTb

clean:
	rm -rf obj_dir
